// File: usb_link_pkg.sv
// Shared types and constants for the link-state block; timeouts are in microsecond ticks
`default_nettype none

package usb_link_pkg;

  ////////////////////////////////////////
  // Link state encoding
  ////////////////////////////////////////

  // Encodings are visible in REG_STATUS and must not move
  typedef enum logic [2:0] {
    LinkDisconnected     = 3'd0,
    LinkPowered          = 3'd1,
    LinkPoweredSuspended = 3'd2,
    LinkActive           = 3'd3,
    LinkSuspended        = 3'd4,
    LinkActiveNoSof      = 3'd5,
    LinkResuming         = 3'd6
  } link_state_e;

  ////////////////////////////////////////
  // Timing
  ////////////////////////////////////////

  // Clocks per microsecond
  localparam int                    TICK_W             = 6;
  localparam logic [TICK_W-1:0]     TICK_DIV           = 6'd48;
  // SE0 longer than this is a bus reset
  localparam int                    RST_TIMER_W        = 2;
  localparam logic [RST_TIMER_W-1:0] RESET_TIMEOUT_US  = 2'd3;
  // Idle time before suspend
  localparam int                    INAC_TIMER_W       = 12;
  localparam logic [INAC_TIMER_W-1:0] SUSPEND_TIMEOUT_US = 12'd3000;
  // One frame plus slack for host clock tolerance
  localparam int                    SOF_TIMER_W        = 10;
  localparam logic [SOF_TIMER_W-1:0] SOF_TIMEOUT_US    = 10'd1005;
  // Missed frames before the host counts as gone
  localparam int                    MISSED_W           = 3;
  localparam logic [MISSED_W-1:0]   HOST_LOST_FRAMES   = 3'd4;
  localparam int                    FILTER_CYCLES      = 6;

  // Register map
  localparam logic [1:0] REG_CTRL   = 2'd0;
  localparam logic [1:0] REG_STATUS = 2'd1;
  localparam logic [1:0] REG_EVENTS = 2'd2;

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  // Raw line and receiver observations
  typedef struct packed {
    logic sense;
    logic dp;
    logic dn;
    logic oe;
    logic rx_idle;
    logic rx_j;
    logic sof;
  } line_obs_t;

  // Link outputs; resume and sof_missed are pulses, the rest are levels
  typedef struct packed {
    link_state_e link_state;
    logic        disconnect;
    logic        powered;
    logic        reset;
    logic        active;
    logic        suspend;
    logic        host_lost;
    logic        resume;
    logic        sof_missed;
  } link_status_t;

  // Sticky flags, bit 4 down to bit 0 in REG_EVENTS
  typedef struct packed {
    logic reset_seen;
    logic resume_seen;
    logic sof_missed_seen;
    logic host_lost_seen;
    logic suspend_seen;
  } link_events_t;

endpackage

`default_nettype wire

// File: usb_glitch_filter.sv
// Input must be synchronous to clk_48mhz_i; output lags a stable input by about CYCLES clocks
`default_nettype none
`timescale 1ns/100ps

module usb_glitch_filter #(
  parameter int CYCLES = usb_link_pkg::FILTER_CYCLES
) (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  input  logic filter_i,
  output logic filter_o
);

  logic                             in_q;
  logic [$clog2(CYCLES+1)-1:0]      cnt_q;

  // Counter tracks how long the input has held its last value
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_q     <= 1'b0;
      cnt_q    <= '0;
      filter_o <= 1'b0;
    end else begin
      in_q <= filter_i;
      if (filter_i != in_q) begin
        // Any change restarts the count
        cnt_q <= '0;
      end else if (int'(cnt_q) != CYCLES) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // Stable long enough, pass the value on
      if (int'(cnt_q) == CYCLES) begin
        filter_o <= in_q;
      end
    end
  end

endmodule

`default_nettype wire

// File: usb_us_tick_gen.sv
// Needs an exact 48 MHz clock; first tick comes TICK_DIV clocks after reset release
`default_nettype none
`timescale 1ns/100ps

module usb_us_tick_gen (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  output logic us_tick_o
);

  logic [usb_link_pkg::TICK_W-1:0] cnt_q;

  // Free-running modulo counter
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (us_tick_o) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Tick on the last count of each period
  assign us_tick_o = (cnt_q == usb_link_pkg::TICK_DIV - 6'd1);

endmodule

`default_nettype wire

// File: usb_link_regs.sv
// Single-cycle writes and combinational reads; event flags are cleared only by writing a 1
`default_nettype none
`timescale 1ns/100ps

module usb_link_regs (
  input  logic                       clk_48mhz_i,
  input  logic                       rst_ni,
  input  logic                       reg_we_i,
  input  logic [1:0]                 reg_addr_i,
  input  logic [7:0]                 reg_wdata_i,
  output logic [7:0]                 reg_rdata_o,
  input  usb_link_pkg::link_status_t status_i,
  output logic                       pullup_en_o,
  output logic                       resume_req_o
);

  logic                       ctrl_we;
  logic                       events_we;
  // Previous samples of the levels that set flags on their rising edge
  logic                       reset_q;
  logic                       host_lost_q;
  logic                       suspend_q;
  usb_link_pkg::link_events_t events_q;
  usb_link_pkg::link_events_t events_set;
  usb_link_pkg::link_events_t events_clr;

  assign ctrl_we   = reg_we_i && (reg_addr_i == usb_link_pkg::REG_CTRL);
  assign events_we = reg_we_i && (reg_addr_i == usb_link_pkg::REG_EVENTS);

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  // Bit 0 holds the pull-up, bit 1 fires a one-cycle resume request
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pullup_en_o  <= 1'b0;
      resume_req_o <= 1'b0;
    end else begin
      resume_req_o <= ctrl_we & reg_wdata_i[1];
      if (ctrl_we) begin
        pullup_en_o <= reg_wdata_i[0];
      end
    end
  end

  ////////////////////////////////////////
  // Sticky events
  ////////////////////////////////////////

  always_comb begin
    events_set.reset_seen      = status_i.reset & ~reset_q;
    events_set.resume_seen     = status_i.resume;
    events_set.sof_missed_seen = status_i.sof_missed;
    events_set.host_lost_seen  = status_i.host_lost & ~host_lost_q;
    events_set.suspend_seen    = status_i.suspend & ~suspend_q;
  end

  // Write 1 to clear; a new event in the same cycle wins
  assign events_clr = events_we ? usb_link_pkg::link_events_t'(reg_wdata_i[4:0]) : '0;

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reset_q     <= 1'b0;
      host_lost_q <= 1'b0;
      suspend_q   <= 1'b0;
      events_q    <= '0;
    end else begin
      reset_q     <= status_i.reset;
      host_lost_q <= status_i.host_lost;
      suspend_q   <= status_i.suspend;
      events_q    <= (events_q & ~events_clr) | events_set;
    end
  end

  // Read mux
  always_comb begin
    case (reg_addr_i)
      usb_link_pkg::REG_CTRL:   reg_rdata_o = {7'b0, pullup_en_o};
      usb_link_pkg::REG_STATUS: reg_rdata_o = {2'b0, status_i.reset, status_i.host_lost,
                                               status_i.powered, status_i.link_state};
      usb_link_pkg::REG_EVENTS: reg_rdata_o = {3'b0, events_q};
      default:                  reg_rdata_o = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

// File: usb_linkstate.sv
// Filtered SE0 and sense come from outside; all other line inputs must already be synchronous
`default_nettype none
`timescale 1ns/100ps

module usb_linkstate (
  input  logic                       clk_48mhz_i,
  input  logic                       rst_ni,
  input  logic                       us_tick_i,
  input  usb_link_pkg::line_obs_t    line_i,
  input  logic                       se0_filt_i,
  input  logic                       sense_filt_i,
  input  logic                       pullup_en_i,
  input  logic                       resume_req_i,
  output logic                       se0_raw_o,
  output usb_link_pkg::link_status_t status_o
);

  typedef enum logic [1:0] {
    RstIdle,
    RstCount,
    RstPend
  } rst_state_e;

  typedef enum logic [1:0] {
    InacActive,
    InacCount,
    InacPend
  } inac_state_e;

  usb_link_pkg::link_state_e state_d, state_q;
  logic link_active;
  logic link_resume;

  // Bus reset detection
  rst_state_e                           rst_state_d, rst_state_q;
  logic [usb_link_pkg::RST_TIMER_W-1:0] rst_timer_d, rst_timer_q;
  logic                                 ev_reset;
  logic                                 link_reset;

  // Inactivity detection
  inac_state_e                           inac_state_d, inac_state_q;
  logic [usb_link_pkg::INAC_TIMER_W-1:0] inac_timer_d, inac_timer_q;
  logic                                  monitor_inac;
  logic                                  ev_bus_active;
  logic                                  ev_bus_inactive;

  // Frame loss
  logic [usb_link_pkg::SOF_TIMER_W-1:0] sof_timer_q;
  logic [usb_link_pkg::MISSED_W-1:0]    missed_q;
  logic                                 sof_missed;
  logic                                 host_lost;

  // SE0 only counts while the device itself is not driving
  assign se0_raw_o = ~line_i.dp & ~line_i.dn & ~line_i.oe;

  assign ev_bus_active = ~line_i.rx_idle;
  assign link_active   = (state_q == usb_link_pkg::LinkActive) ||
                         (state_q == usb_link_pkg::LinkActiveNoSof);
  // Idle only matters once attached and not already suspended
  assign monitor_inac  = sense_filt_i &&
                         ((state_q == usb_link_pkg::LinkPowered) || link_active);

  ////////////////////////////////////////
  // Main link FSM
  ////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    link_resume = 1'b0;
    if (!sense_filt_i || !pullup_en_i) begin
      // VBUS gone or pull-up off
      state_d = usb_link_pkg::LinkDisconnected;
    end else begin
      case (state_q)
        usb_link_pkg::LinkDisconnected: begin
          state_d = usb_link_pkg::LinkPowered;
        end
        usb_link_pkg::LinkPowered: begin
          if (ev_reset) begin
            state_d = usb_link_pkg::LinkActiveNoSof;
          end else if (resume_req_i) begin
            // Software asks for resume signalling
            state_d = usb_link_pkg::LinkResuming;
          end else if (ev_bus_inactive) begin
            state_d = usb_link_pkg::LinkPoweredSuspended;
          end
        end
        usb_link_pkg::LinkPoweredSuspended: begin
          if (ev_reset) begin
            state_d = usb_link_pkg::LinkActiveNoSof;
          end else if (ev_bus_active) begin
            link_resume = 1'b1;
            state_d     = usb_link_pkg::LinkPowered;
          end
        end
        // Wait for the end of resume signalling, seen as a J or a reset
        usb_link_pkg::LinkResuming: begin
          if (line_i.rx_j || ev_reset) begin
            link_resume = 1'b1;
            state_d     = usb_link_pkg::LinkActiveNoSof;
          end
        end
        usb_link_pkg::LinkActiveNoSof: begin
          if (ev_bus_inactive) begin
            state_d = usb_link_pkg::LinkSuspended;
          end else if (line_i.sof) begin
            state_d = usb_link_pkg::LinkActive;
          end
        end
        usb_link_pkg::LinkActive: begin
          if (ev_bus_inactive) begin
            state_d = usb_link_pkg::LinkSuspended;
          end else if (ev_reset) begin
            state_d = usb_link_pkg::LinkActiveNoSof;
          end
        end
        usb_link_pkg::LinkSuspended: begin
          if (ev_reset) begin
            link_resume = 1'b1;
            state_d     = usb_link_pkg::LinkActiveNoSof;
          end else if (ev_bus_active) begin
            state_d = usb_link_pkg::LinkResuming;
          end
        end
        default: state_d = usb_link_pkg::LinkDisconnected;
      endcase
    end
  end

  ////////////////////////////////////////
  // Reset and inactivity timers
  ////////////////////////////////////////

  always_comb begin
    rst_state_d = rst_state_q;
    rst_timer_d = rst_timer_q;
    ev_reset    = 1'b0;
    case (rst_state_q)
      RstIdle: begin
        rst_timer_d = '0;
        if (se0_filt_i) begin
          rst_state_d = RstCount;
        end
      end
      RstCount: begin
        if (!se0_filt_i) begin
          rst_state_d = RstIdle;
        end else if (us_tick_i) begin
          // Full timeout seen, now wait for the SE0 to end
          if (rst_timer_q == usb_link_pkg::RESET_TIMEOUT_US) begin
            rst_state_d = RstPend;
          end else begin
            rst_timer_d = rst_timer_q + 1'b1;
          end
        end
      end
      RstPend: begin
        if (!se0_filt_i) begin
          rst_state_d = RstIdle;
          ev_reset    = 1'b1;
        end
      end
      default: rst_state_d = RstIdle;
    endcase
  end

  assign link_reset = (rst_state_q == RstPend);

  always_comb begin
    inac_state_d    = inac_state_q;
    inac_timer_d    = inac_timer_q;
    ev_bus_inactive = 1'b0;
    case (inac_state_q)
      InacActive: begin
        inac_timer_d = '0;
        if (!ev_bus_active && monitor_inac) begin
          inac_state_d = InacCount;
        end
      end
      InacCount: begin
        if (ev_bus_active || !monitor_inac) begin
          inac_state_d = InacActive;
        end else if (us_tick_i) begin
          inac_timer_d = inac_timer_q + 1'b1;
          // Single event when the count reaches the timeout
          if (inac_timer_d == usb_link_pkg::SUSPEND_TIMEOUT_US) begin
            inac_state_d    = InacPend;
            ev_bus_inactive = 1'b1;
          end
        end
      end
      InacPend: begin
        if (ev_bus_active || !monitor_inac) begin
          inac_state_d = InacActive;
        end
      end
      default: inac_state_d = InacActive;
    endcase
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= usb_link_pkg::LinkDisconnected;
      rst_state_q  <= RstIdle;
      rst_timer_q  <= '0;
      inac_state_q <= InacActive;
      inac_timer_q <= '0;
    end else begin
      state_q      <= state_d;
      rst_state_q  <= rst_state_d;
      rst_timer_q  <= rst_timer_d;
      inac_state_q <= inac_state_d;
      inac_timer_q <= inac_timer_d;
    end
  end

  ////////////////////////////////////////
  // SOF loss and host loss
  ////////////////////////////////////////

  assign sof_missed = (sof_timer_q == usb_link_pkg::SOF_TIMEOUT_US);
  // Saturated count of 4 sets bit 2
  assign host_lost  = missed_q[2];

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sof_timer_q <= '0;
      missed_q    <= '0;
    end else if (line_i.sof || !link_active || link_reset) begin
      sof_timer_q <= '0;
      missed_q    <= '0;
    end else begin
      if (sof_missed) begin
        sof_timer_q <= '0;
      end else if (us_tick_i) begin
        sof_timer_q <= sof_timer_q + 1'b1;
      end
      if (sof_missed && (missed_q != usb_link_pkg::HOST_LOST_FRAMES)) begin
        missed_q <= missed_q + 1'b1;
      end
    end
  end

  // Status bundle
  always_comb begin
    status_o.link_state = state_q;
    status_o.disconnect = (state_q == usb_link_pkg::LinkDisconnected);
    status_o.powered    = sense_filt_i;
    status_o.reset      = link_reset;
    status_o.active     = link_active;
    status_o.suspend    = (state_q == usb_link_pkg::LinkSuspended) ||
                          (state_q == usb_link_pkg::LinkPoweredSuspended);
    status_o.host_lost  = host_lost;
    status_o.resume     = link_resume;
    status_o.sof_missed = sof_missed;
  end

endmodule

`default_nettype wire

// File: usb_link_top.sv
// Line inputs must be synchronous to clk_48mhz_i; the register port has no wait states
`default_nettype none
`timescale 1ns/100ps

module usb_link_top (
  input  logic                       clk_48mhz_i,
  input  logic                       rst_ni,
  input  usb_link_pkg::line_obs_t    line_obs_i,
  input  logic                       reg_we_i,
  input  logic [1:0]                 reg_addr_i,
  input  logic [7:0]                 reg_wdata_i,
  output logic [7:0]                 reg_rdata_o,
  output usb_link_pkg::link_status_t link_status_o
);

  logic us_tick;
  logic se0_raw;
  logic se0_filt;
  logic sense_filt;
  logic pullup_en;
  logic resume_req;

  // Microsecond time base
  usb_us_tick_gen i_tick_gen (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .us_tick_o   (us_tick)
  );

  ////////////////////////////////////////
  // Line filters
  ////////////////////////////////////////

  usb_glitch_filter i_se0_filter (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .filter_i    (se0_raw),
    .filter_o    (se0_filt)
  );

  usb_glitch_filter i_sense_filter (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .filter_i    (line_obs_i.sense),
    .filter_o    (sense_filt)
  );

  // Link state detection
  usb_linkstate i_linkstate (
    .clk_48mhz_i  (clk_48mhz_i),
    .rst_ni       (rst_ni),
    .us_tick_i    (us_tick),
    .line_i       (line_obs_i),
    .se0_filt_i   (se0_filt),
    .sense_filt_i (sense_filt),
    .pullup_en_i  (pullup_en),
    .resume_req_i (resume_req),
    .se0_raw_o    (se0_raw),
    .status_o     (link_status_o)
  );

  // Software-facing registers
  usb_link_regs i_regs (
    .clk_48mhz_i  (clk_48mhz_i),
    .rst_ni       (rst_ni),
    .reg_we_i     (reg_we_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .status_i     (link_status_o),
    .pullup_en_o  (pullup_en),
    .resume_req_o (resume_req)
  );

endmodule

`default_nettype wire

// File: usb_link_assert.sv
// Invariants of usb_linkstate bound into every instance; checks are off while rst_ni is low
`default_nettype none
`timescale 1ns/100ps

module usb_link_assert (
  input logic                       clk_48mhz_i,
  input logic                       rst_ni,
  input logic                       sense_filt_i,
  input usb_link_pkg::line_obs_t    line_i,
  input usb_link_pkg::link_status_t status_i
);

  // Failure count, read by the testbench at the end
  int fail_count = 0;

  ////////////////////////////////////////
  // State and pulse shape
  ////////////////////////////////////////

  state_legal: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    status_i.link_state <= usb_link_pkg::LinkResuming)
    else begin
      $error("link state holds an illegal encoding");
      fail_count++;
    end

  resume_one_cycle: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    status_i.resume |=> !status_i.resume)
    else begin
      $error("resume pulse lasted more than one cycle");
      fail_count++;
    end

  sof_missed_one_cycle: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    status_i.sof_missed |=> !status_i.sof_missed)
    else begin
      $error("sof_missed pulse lasted more than one cycle");
      fail_count++;
    end

  ////////////////////////////////////////
  // Attach and host loss
  ////////////////////////////////////////

  // VBUS loss always forces a disconnect on the next clock
  no_sense_disconnect: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !sense_filt_i |=> (status_i.link_state == usb_link_pkg::LinkDisconnected))
    else begin
      $error("state not disconnected one cycle after sense loss");
      fail_count++;
    end

  // Host loss clears only on SOF, bus reset or leaving the active states
  host_lost_hold: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    $fell(status_i.host_lost) |->
      ($past(line_i.sof) || $past(status_i.reset) || !$past(status_i.active)))
    else begin
      $error("host_lost fell while active without SOF");
      fail_count++;
    end

endmodule

bind usb_linkstate usb_link_assert i_assert (
  .clk_48mhz_i  (clk_48mhz_i),
  .rst_ni       (rst_ni),
  .sense_filt_i (sense_filt_i),
  .line_i       (line_i),
  .status_i     (status_o)
);

`default_nettype wire

// File: usb_link_tb.sv
// Table-driven test of usb_link_top; one microsecond is 48 cycles of the 20 ns test clock
`default_nettype none
`timescale 1ns/100ps

module usb_link_tb;

  // One table row: stimulus, optional write, hold and expected result
  typedef struct packed {
    usb_link_pkg::line_obs_t   line;
    logic                      we;
    logic [1:0]                waddr;
    logic [7:0]                wdata;
    logic [1:0]                glitch;
    logic [11:0]               hold_us;
    usb_link_pkg::link_state_e exp_state;
    logic [1:0]                chk_addr;
    logic [7:0]                exp_data;
    logic [7:0]                chk_mask;
  } step_t;

  logic                       clk_48mhz = 1'b0;
  logic                       rst_n;
  usb_link_pkg::line_obs_t    line_obs;
  logic                       reg_we;
  logic [1:0]                 reg_addr;
  logic [7:0]                 reg_wdata;
  logic [7:0]                 reg_rdata;
  usb_link_pkg::link_status_t link_status;

  // Common line patterns
  usb_link_pkg::line_obs_t line_off;
  usb_link_pkg::line_obs_t line_on;
  usb_link_pkg::line_obs_t line_se0;
  usb_link_pkg::line_obs_t line_idle;
  usb_link_pkg::line_obs_t line_j;
  usb_link_pkg::line_obs_t line_sof;

  step_t       steps [0:31];
  int          num_steps = 0;
  int          checks    = 0;
  int          errors    = 0;
  int          timeouts  = 0;
  logic [31:0] rng_state;

  always #10 clk_48mhz = ~clk_48mhz;

  usb_link_top i_dut (
    .clk_48mhz_i   (clk_48mhz),
    .rst_ni        (rst_n),
    .line_obs_i    (line_obs),
    .reg_we_i      (reg_we),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_rdata_o   (reg_rdata),
    .link_status_o (link_status)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Xorshift32 generator
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Expected disconnect, active and suspend levels for each link state
  function automatic logic [2:0] state_levels(input usb_link_pkg::link_state_e state);
    case (state)
      usb_link_pkg::LinkDisconnected:     return 3'b100;
      usb_link_pkg::LinkActive,
      usb_link_pkg::LinkActiveNoSof:      return 3'b010;
      usb_link_pkg::LinkSuspended,
      usb_link_pkg::LinkPoweredSuspended: return 3'b001;
      default:                            return 3'b000;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail at %0t ns: %s expected 0x%02h, got 0x%02h", $time, name, expected, actual);
    end
  endtask

  task automatic add_step(input usb_link_pkg::line_obs_t line, input logic we,
                          input logic [1:0] waddr, input logic [7:0] wdata,
                          input logic [1:0] glitch, input logic [11:0] hold_us,
                          input usb_link_pkg::link_state_e exp_state,
                          input logic [1:0] chk_addr, input logic [7:0] exp_data,
                          input logic [7:0] chk_mask);
    steps[num_steps] = '{line, we, waddr, wdata, glitch, hold_us, exp_state,
                         chk_addr, exp_data, chk_mask};
    num_steps++;
  endtask

  // Short SE0 (kind 1) or sense drop (kind 2) pulses, 1 to 5 cycles wide
  task automatic apply_glitches(input logic [1:0] kind, input usb_link_pkg::line_obs_t base);
    usb_link_pkg::line_obs_t glitch_line;
    int                      n;
    int                      width;
    int                      gap;
    logic                    leaked;
    glitch_line = base;
    leaked      = 1'b0;
    if (kind == 2'd1) begin
      glitch_line.dp = 1'b0;
    end else begin
      glitch_line.sense = 1'b0;
    end
    for (n = 0; n < 4; n++) begin
      width    = 1 + int'(next_random() % 5);
      gap      = 12 + int'(next_random() % 20);
      line_obs = glitch_line;
      repeat (width) begin
        @(negedge clk_48mhz);
        leaked = leaked | i_dut.se0_filt | ~link_status.powered;
      end
      line_obs = base;
      repeat (gap) begin
        @(negedge clk_48mhz);
        leaked = leaked | i_dut.se0_filt | ~link_status.powered;
      end
    end
    // Neither filtered SE0 nor filtered sense may follow a short pulse
    check_value("filtered_line", 8'h00, {7'b0, leaked});
  endtask

  task automatic run_step(input int idx, input step_t step);
    int hold;
    int waited;
    line_obs = step.line;
    if (step.we) begin
      reg_we    = 1'b1;
      reg_addr  = step.waddr;
      reg_wdata = step.wdata;
      @(negedge clk_48mhz);
      reg_we    = 1'b0;
      reg_wdata = 8'h00;
    end
    reg_addr = step.chk_addr;
    if (step.glitch != 2'd0) begin
      apply_glitches(step.glitch, step.line);
    end
    // Zero hold means a single-cycle pulse
    hold = (step.hold_us == 12'd0) ? 1 : int'(step.hold_us) * int'(usb_link_pkg::TICK_DIV);
    repeat (hold) @(negedge clk_48mhz);
    waited = 0;
    while ((link_status.link_state != step.exp_state) &&
           (waited < 200 * int'(usb_link_pkg::TICK_DIV))) begin
      @(negedge clk_48mhz);
      waited++;
    end
    if (link_status.link_state != step.exp_state) begin
      errors++;
      timeouts++;
      $display("Step %0d timed out: link state stayed at %0d instead of reaching %0d",
               idx, link_status.link_state, step.exp_state);
    end else begin
      check_value("reg_rdata", step.exp_data & step.chk_mask, reg_rdata & step.chk_mask);
      check_value("link_levels", {5'b0, state_levels(step.exp_state)},
                  {5'b0, link_status.disconnect, link_status.active, link_status.suspend});
    end
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  task automatic load_steps();
    // Attach, detach and glitch rejection
    add_step(line_on, 1'b0, 2'd0, 8'h00, 2'd0, 12'd2,
             usb_link_pkg::LinkDisconnected, usb_link_pkg::REG_STATUS, 8'h08, 8'hff);
    add_step(line_on, 1'b1, usb_link_pkg::REG_CTRL, 8'h01, 2'd0, 12'd1,
             usb_link_pkg::LinkPowered, usb_link_pkg::REG_STATUS, 8'h09, 8'hff);
    add_step(line_off, 1'b0, 2'd0, 8'h00, 2'd0, 12'd1,
             usb_link_pkg::LinkDisconnected, usb_link_pkg::REG_STATUS, 8'h00, 8'hff);
    add_step(line_on, 1'b0, 2'd0, 8'h00, 2'd0, 12'd1,
             usb_link_pkg::LinkPowered, usb_link_pkg::REG_STATUS, 8'h09, 8'hff);
    add_step(line_on, 1'b0, 2'd0, 8'h00, 2'd1, 12'd1,
             usb_link_pkg::LinkPowered, usb_link_pkg::REG_STATUS, 8'h09, 8'hff);
    add_step(line_on, 1'b0, 2'd0, 8'h00, 2'd2, 12'd1,
             usb_link_pkg::LinkPowered, usb_link_pkg::REG_EVENTS, 8'h00, 8'hff);
    // Bus reset, reset level shows while SE0 lasts
    add_step(line_se0, 1'b0, 2'd0, 8'h00, 2'd0, 12'd5,
             usb_link_pkg::LinkPowered, usb_link_pkg::REG_STATUS, 8'h29, 8'hff);
    add_step(line_on, 1'b0, 2'd0, 8'h00, 2'd0, 12'd1,
             usb_link_pkg::LinkActiveNoSof, usb_link_pkg::REG_EVENTS, 8'h10, 8'hff);
    add_step(line_se0, 1'b0, 2'd0, 8'h00, 2'd0, 12'd1,
             usb_link_pkg::LinkActiveNoSof, usb_link_pkg::REG_STATUS, 8'h0d, 8'hff);
    add_step(line_on, 1'b0, 2'd0, 8'h00, 2'd0, 12'd1,
             usb_link_pkg::LinkActiveNoSof, usb_link_pkg::REG_STATUS, 8'h0d, 8'hff);
    add_step(line_sof, 1'b0, 2'd0, 8'h00, 2'd0, 12'd0,
             usb_link_pkg::LinkActive, usb_link_pkg::REG_STATUS, 8'h0b, 8'hff);
    add_step(line_on, 1'b1, usb_link_pkg::REG_EVENTS, 8'h1f, 2'd0, 12'd1,
             usb_link_pkg::LinkActive, usb_link_pkg::REG_EVENTS, 8'h00, 8'hff);
    // Frame loss, four misses make host_lost
    add_step(line_on, 1'b0, 2'd0, 8'h00, 2'd0, 12'd1010,
             usb_link_pkg::LinkActive, usb_link_pkg::REG_EVENTS, 8'h04, 8'hff);
    add_step(line_on, 1'b0, 2'd0, 8'h00, 2'd0, 12'd3030,
             usb_link_pkg::LinkActive, usb_link_pkg::REG_STATUS, 8'h1b, 8'hff);
    add_step(line_sof, 1'b0, 2'd0, 8'h00, 2'd0, 12'd0,
             usb_link_pkg::LinkActive, usb_link_pkg::REG_STATUS, 8'h0b, 8'hff);
    // Suspend from active, resume through a J
    add_step(line_on, 1'b1, usb_link_pkg::REG_EVENTS, 8'h1f, 2'd0, 12'd1,
             usb_link_pkg::LinkActive, usb_link_pkg::REG_EVENTS, 8'h00, 8'hff);
    add_step(line_idle, 1'b0, 2'd0, 8'h00, 2'd0, 12'd3010,
             usb_link_pkg::LinkSuspended, usb_link_pkg::REG_EVENTS, 8'h01, 8'h01);
    add_step(line_on, 1'b0, 2'd0, 8'h00, 2'd0, 12'd1,
             usb_link_pkg::LinkResuming, usb_link_pkg::REG_STATUS, 8'h0e, 8'hff);
    add_step(line_j, 1'b0, 2'd0, 8'h00, 2'd0, 12'd0,
             usb_link_pkg::LinkActiveNoSof, usb_link_pkg::REG_EVENTS, 8'h08, 8'h08);
    // Powered suspend, then resume request
    add_step(line_on, 1'b1, usb_link_pkg::REG_CTRL, 8'h00, 2'd0, 12'd1,
             usb_link_pkg::LinkDisconnected, usb_link_pkg::REG_CTRL, 8'h00, 8'hff);
    add_step(line_on, 1'b1, usb_link_pkg::REG_CTRL, 8'h01, 2'd0, 12'd1,
             usb_link_pkg::LinkPowered, usb_link_pkg::REG_STATUS, 8'h09, 8'hff);
    add_step(line_on, 1'b1, usb_link_pkg::REG_EVENTS, 8'h1f, 2'd0, 12'd1,
             usb_link_pkg::LinkPowered, usb_link_pkg::REG_EVENTS, 8'h00, 8'hff);
    add_step(line_idle, 1'b0, 2'd0, 8'h00, 2'd0, 12'd3010,
             usb_link_pkg::LinkPoweredSuspended, usb_link_pkg::REG_EVENTS, 8'h01, 8'hff);
    add_step(line_on, 1'b0, 2'd0, 8'h00, 2'd0, 12'd1,
             usb_link_pkg::LinkPowered, usb_link_pkg::REG_EVENTS, 8'h09, 8'hff);
    add_step(line_on, 1'b1, usb_link_pkg::REG_CTRL, 8'h03, 2'd0, 12'd1,
             usb_link_pkg::LinkResuming, usb_link_pkg::REG_CTRL, 8'h01, 8'hff);
    add_step(line_on, 1'b1, usb_link_pkg::REG_EVENTS, 8'h1f, 2'd0, 12'd1,
             usb_link_pkg::LinkResuming, usb_link_pkg::REG_EVENTS, 8'h00, 8'hff);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int idx;
    // Fields: sense, dp, dn, oe, rx_idle, rx_j, sof
    line_off  = 7'b0100000;
    line_on   = 7'b1100000;
    line_se0  = 7'b1000000;
    line_idle = 7'b1100100;
    line_j    = 7'b1100010;
    line_sof  = 7'b1100001;
    rng_state = 32'h9a211147;
    rst_n     = 1'b0;
    line_obs  = line_off;
    reg_we    = 1'b0;
    reg_addr  = 2'd0;
    reg_wdata = 8'h00;
    load_steps();
    repeat (10) @(negedge clk_48mhz);
    rst_n = 1'b1;
    idx   = 0;
    // Stop at the first timeout, later rows depend on the state
    while ((idx < num_steps) && (timeouts == 0)) begin
      run_step(idx, steps[idx]);
      idx++;
    end
    $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
             checks, errors, timeouts, i_dut.i_linkstate.i_assert.fail_count);
    if ((errors == 0) && (i_dut.i_linkstate.i_assert.fail_count == 0)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: usb_link.f
usb_link_pkg.sv
usb_glitch_filter.sv
usb_us_tick_gen.sv
usb_link_regs.sv
usb_linkstate.sv
usb_link_top.sv
usb_link_assert.sv
usb_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module usb_link_tb -f usb_link.f -o usb_link_sim \
  || { echo "Build failed"; exit 1; }
sim_out=$(./obj_dir/usb_link_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "^RESULT: PASS$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
